//--- build.f
common/fbw_pkg.sv
src/pixel_fifo.sv
fb_writer/fbw_flush_counter.sv
fb_writer/fbw_cmd_reg.sv
fb_writer/fbw_ctrl.sv
src/fbw_top.sv
tests/tb_clkgen.sv
tests/tb_fbw_top.sv

//--- Bender.yml
package:
  name: fbw

sources:
  - common/fbw_pkg.sv
  - src/pixel_fifo.sv
  - fb_writer/fbw_flush_counter.sv
  - fb_writer/fbw_cmd_reg.sv
  - fb_writer/fbw_ctrl.sv
  - src/fbw_top.sv
  - target: test
    files:
      - tests/tb_clkgen.sv
      - tests/tb_fbw_top.sv

//--- tests/tb_fbw_top.sv
module tb_fbw_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam fbw_pkg::fb_base_t TB_BASE = 11'h5A3;
  localparam int TB_LINES     = 3;
  localparam int TB_COLS      = 4;
  localparam int N_TESTS      = 4;
  localparam int MAX_WORDS    = 6;
  localparam int SEED         = 1716;
  localparam int RST_TIMEOUT  = 50;
  localparam int FULL_TIMEOUT = 200;
  localparam int IDLE_TIMEOUT = 1000;

  // Back-pressure modes
  localparam int BP_FAST   = 0;
  localparam int BP_RANDOM = 1;
  localparam int BP_SLOW   = 2;

  // Bus slave phases
  localparam int BUS_IDLE       = 0;
  localparam int BUS_ACK_WAIT   = 1;
  localparam int BUS_ACKED      = 2;
  localparam int BUS_CMPLT_WAIT = 3;

  logic                  PLB_clk;
  logic                  arst_n;
  logic                  push;
  fbw_pkg::raster_word_t push_data;
  logic                  full;
  logic                  mst_wr_req;
  fbw_pkg::addr_t        mst_addr;
  fbw_pkg::color_t       mst_wr_d;
  logic                  mst_cmd_ack;
  logic                  mst_cmplt;
  logic                  idle;

  // Stimulus table
  string                 t_name  [N_TESTS];
  int                    t_count [N_TESTS];
  fbw_pkg::raster_word_t t_words [N_TESTS][MAX_WORDS];
  int                    t_mode  [N_TESTS];
  int                    t_exp   [N_TESTS];
  bit                    t_full  [N_TESTS];

  fbw_pkg::addr_t  exp_addr [$];
  fbw_pkg::color_t exp_data [$];

  string cur_name;
  int    cur_mode;
  int    err_cnt;
  int    test_err;
  int    failed_tests;
  int    wr_cnt;
  bit    full_seen;
  bit    aborted;

  tb_clkgen #(
    .PERIOD_NS  (40),
    .RST_CYCLES (8)
  ) u_clkgen (
    .PLB_clk (PLB_clk),
    .arst_n  (arst_n)
  );

  fbw_top #(
    .FB_BASE     (TB_BASE),
    .FLUSH_LINES (TB_LINES),
    .FLUSH_COLS  (TB_COLS),
    .FIFO_DEPTH  (4)
  ) u_dut (
    .PLB_clk     (PLB_clk),
    .arst_n      (arst_n),
    .push        (push),
    .push_data   (push_data),
    .full        (full),
    .mst_wr_req  (mst_wr_req),
    .mst_addr    (mst_addr),
    .mst_wr_d    (mst_wr_d),
    .mst_cmd_ack (mst_cmd_ack),
    .mst_cmplt   (mst_cmplt),
    .idle        (idle)
  );

  //////////////////////////////////////////////////
  // Reporting and expected writes
  //////////////////////////////////////////////////

  task automatic note_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s %s: expected %h actual %h", cur_name, what, exp, act);
    err_cnt++;
    test_err++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s: %s", cur_name, msg);
    err_cnt++;
    test_err++;
  endtask

  function automatic fbw_pkg::raster_word_t make_pixel(input int line, input int col,
                                                       input logic [31:0] color);
    fbw_pkg::raster_word_t w;
    w       = '0;
    w.line  = fbw_pkg::line_t'(line);
    w.col   = fbw_pkg::col_t'(col);
    w.color = color;
    return w;
  endfunction

  // Base in bits 31..21, line in 20..12, column in 11..2
  function automatic fbw_pkg::addr_t pixel_addr(input fbw_pkg::line_t line,
                                                input fbw_pkg::col_t col);
    fbw_pkg::addr_t a;
    a = fbw_pkg::addr_t'(TB_BASE) << 21;
    a = a | (fbw_pkg::addr_t'(line) << 12);
    a = a | (fbw_pkg::addr_t'(col) << 2);
    return a;
  endfunction

  // Marker expands to the whole region in descending column-first order
  task automatic expect_word(input fbw_pkg::raster_word_t w);
    if (&w)
    begin
      for (int l = TB_LINES - 1; l >= 0; l--)
        for (int c = TB_COLS - 1; c >= 0; c--)
        begin
          exp_addr.push_back(pixel_addr(fbw_pkg::line_t'(l), fbw_pkg::col_t'(c)));
          exp_data.push_back(32'h0);
        end
    end
    else
    begin
      exp_addr.push_back(pixel_addr(w.line, w.col));
      exp_data.push_back(w.color);
    end
  endtask

  task automatic load_table();
    t_name[0]  = "reset_state";
    t_count[0] = 0;
    t_mode[0]  = BP_FAST;
    t_exp[0]   = 0;
    t_full[0]  = 1'b0;

    t_name[1]     = "single_pixel";
    t_count[1]    = 1;
    t_words[1][0] = make_pixel(5, 17, 32'hCAFE_0001);
    t_mode[1]     = BP_RANDOM;
    t_exp[1]      = 1;
    t_full[1]     = 1'b0;

    t_name[2]  = "fifo_burst";
    t_count[2] = 6;
    for (int i = 0; i < 6; i++)
      t_words[2][i] = make_pixel(3 * i + 1, 40 + 7 * i, 32'h1000_0000 + i);
    t_mode[2]  = BP_SLOW;
    t_exp[2]   = 6;
    t_full[2]  = 1'b1;

    t_name[3]     = "flush_marker";
    t_count[3]    = 2;
    t_words[3][0] = '1;
    t_words[3][1] = make_pixel(2, 3, 32'hBEEF_0003);
    t_mode[3]     = BP_RANDOM;
    t_exp[3]      = TB_LINES * TB_COLS + 1;
    t_full[3]     = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Bus slave model
  //////////////////////////////////////////////////

  function automatic int ack_delay();
    if (cur_mode == BP_FAST)
      return 0;
    else if (cur_mode == BP_SLOW)
      return 3;
    return $urandom_range(3, 0);
  endfunction

  function automatic int cmplt_delay();
    if (cur_mode == BP_FAST)
      return 1;
    else if (cur_mode == BP_SLOW)
      return 3;
    return $urandom_range(3, 1);
  endfunction

  task automatic check_write(input fbw_pkg::addr_t addr, input fbw_pkg::color_t data);
    fbw_pkg::addr_t  ea;
    fbw_pkg::color_t ed;
    wr_cnt++;
    if (exp_addr.size() == 0)
      note_failure($sformatf("write to %h with no write expected", addr));
    else
    begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      if (addr !== ea)
        note_mismatch("write address", ea, addr);
      if (data !== ed)
        note_mismatch("write data", ed, data);
    end
  endtask

  initial
  begin : bus_model
    int              phase;
    int              cnt;
    fbw_pkg::addr_t  rise_addr;
    fbw_pkg::color_t rise_data;
    mst_cmd_ack = 1'b0;
    mst_cmplt   = 1'b0;
    phase       = BUS_IDLE;
    cnt         = 0;
    void'($urandom(SEED));
    forever
    begin
      @(negedge PLB_clk);
      mst_cmplt = 1'b0;
      if (!arst_n)
      begin
        mst_cmd_ack = 1'b0;
        phase       = BUS_IDLE;
      end
      else
      begin
        if (phase == BUS_IDLE && mst_wr_req)
        begin
          rise_addr = mst_addr;
          rise_data = mst_wr_d;
          cnt       = ack_delay();
          phase     = BUS_ACK_WAIT;
        end
        if (phase == BUS_ACK_WAIT)
        begin
          if (!mst_wr_req)
            note_failure("write request dropped before acknowledge");
          if (mst_addr !== rise_addr)
            note_mismatch("address during request", rise_addr, mst_addr);
          if (mst_wr_d !== rise_data)
            note_mismatch("data during request", rise_data, mst_wr_d);
          if (cnt == 0)
          begin
            mst_cmd_ack = 1'b1;
            phase       = BUS_ACKED;
          end
          else
            cnt--;
        end
        else if (phase == BUS_ACKED)
        begin
          mst_cmd_ack = 1'b0;
          if (mst_wr_req)
            note_failure("write request still high after acknowledge");
          check_write(rise_addr, rise_data);
          cnt   = cmplt_delay();
          phase = BUS_CMPLT_WAIT;
        end
        else if (phase == BUS_CMPLT_WAIT)
        begin
          if (mst_wr_req)
            note_failure("second write request before completion");
          cnt--;
          if (cnt == 0)
          begin
            mst_cmplt = 1'b1;
            phase     = BUS_IDLE;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Raster side and test sequence
  //////////////////////////////////////////////////

  task automatic push_word(input fbw_pkg::raster_word_t w, output bit ok);
    int waited;
    waited = 0;
    if (full)
    begin
      full_seen = 1'b1;
      push      = 1'b0;
    end
    while (full && waited < FULL_TIMEOUT)
    begin
      @(negedge PLB_clk);
      waited++;
    end
    ok = !full;
    if (!ok)
      note_failure("timed out waiting for the FIFO to leave full");
    else
    begin
      push      = 1'b1;
      push_data = w;
      @(negedge PLB_clk);
    end
  endtask

  task automatic wait_idle(output bit ok);
    int waited;
    waited = 0;
    while (!idle && waited < IDLE_TIMEOUT)
    begin
      @(negedge PLB_clk);
      waited++;
    end
    ok = idle;
    if (!ok)
      note_failure("timed out waiting for the writer to go idle");
  endtask

  task automatic sync_reset(output bit ok);
    int waited;
    waited = 0;
    while (arst_n !== 1'b1 && waited < RST_TIMEOUT)
    begin
      @(negedge PLB_clk);
      waited++;
    end
    ok = (arst_n === 1'b1);
    if (!ok)
      note_failure("reset was never released");
    else
      @(negedge PLB_clk);
  endtask

  initial
  begin : main
    bit ok;
    push         = 1'b0;
    push_data    = '0;
    err_cnt      = 0;
    test_err     = 0;
    failed_tests = 0;
    wr_cnt       = 0;
    full_seen    = 1'b0;
    aborted      = 1'b0;
    cur_name     = "reset";
    cur_mode     = BP_FAST;
    load_table();
    sync_reset(ok);
    aborted = !ok;
    for (int t = 0; t < N_TESTS && !aborted; t++)
    begin
      cur_name  = t_name[t];
      cur_mode  = t_mode[t];
      test_err  = 0;
      wr_cnt    = 0;
      full_seen = 1'b0;
      exp_addr.delete();
      exp_data.delete();
      if (mst_wr_req !== 1'b0)
        note_mismatch("mst_wr_req at start", 32'd0, mst_wr_req);
      if (idle !== 1'b1)
        note_mismatch("idle at start", 32'd1, idle);
      for (int w = 0; w < t_count[t]; w++)
        expect_word(t_words[t][w]);
      for (int w = 0; w < t_count[t] && !aborted; w++)
      begin
        push_word(t_words[t][w], ok);
        aborted = !ok;
      end
      push = 1'b0;
      if (!aborted)
      begin
        wait_idle(ok);
        aborted = !ok;
      end
      if (wr_cnt != t_exp[t])
        note_mismatch("write count", t_exp[t], wr_cnt);
      if (t_full[t] && !full_seen)
        note_failure("FIFO full never rose");
      if (test_err != 0)
        failed_tests++;
      $display("%s: %0d of %0d writes, %s", cur_name, wr_cnt, t_exp[t],
               (test_err == 0) ? "ok" : "failed");
    end
    $display("Tests run %0d, failed %0d, errors %0d", N_TESTS, failed_tests, err_cnt);
    if (err_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- tests/tb_clkgen.sv
module tb_clkgen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic PLB_clk,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    PLB_clk = 1'b0;
    forever
      #(PERIOD_NS / 2) PLB_clk = ~PLB_clk;
  end

  // Release away from the rising edge
  initial
  begin
    arst_n = 1'b0;
    repeat (RST_CYCLES)
      @(posedge PLB_clk);
    @(negedge PLB_clk);
    arst_n = 1'b1;
  end

endmodule

//--- src/fbw_top.sv
module fbw_top #(
  parameter fbw_pkg::fb_base_t FB_BASE     = 11'b1001_0000_000,
  parameter int                FLUSH_LINES = 10,
  parameter int                FLUSH_COLS  = 20,
  parameter int                FIFO_DEPTH  = 8
) (
  input  logic                  PLB_clk,
  input  logic                  arst_n,
  input  logic                  push,
  input  fbw_pkg::raster_word_t push_data,
  output logic                  full,
  output logic                  mst_wr_req,
  output fbw_pkg::addr_t        mst_addr,
  output fbw_pkg::color_t       mst_wr_d,
  input  logic                  mst_cmd_ack,
  input  logic                  mst_cmplt,
  output logic                  idle
);

  fbw_pkg::raster_word_t rd_data;
  fbw_pkg::line_t        flush_line;
  fbw_pkg::col_t         flush_col;
  fbw_pkg::mst_cmd_t     cmd;

  logic empty;
  logic pop;
  logic load_pixel;
  logic load_flush;
  logic flush_start;
  logic step;
  logic flush_last;

  pixel_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .PLB_clk   (PLB_clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .rd_data   (rd_data),
    .full      (full),
    .empty     (empty)
  );

  fbw_ctrl u_ctrl (
    .PLB_clk     (PLB_clk),
    .arst_n      (arst_n),
    .empty       (empty),
    .rd_data     (rd_data),
    .flush_last  (flush_last),
    .mst_cmd_ack (mst_cmd_ack),
    .mst_cmplt   (mst_cmplt),
    .pop         (pop),
    .load_pixel  (load_pixel),
    .load_flush  (load_flush),
    .flush_start (flush_start),
    .step        (step),
    .mst_wr_req  (mst_wr_req),
    .idle        (idle)
  );

  fbw_flush_counter #(
    .FLUSH_LINES (FLUSH_LINES),
    .FLUSH_COLS  (FLUSH_COLS)
  ) u_flush (
    .PLB_clk     (PLB_clk),
    .arst_n      (arst_n),
    .flush_start (flush_start),
    .step        (step),
    .line        (flush_line),
    .col         (flush_col),
    .last        (flush_last)
  );

  fbw_cmd_reg #(
    .FB_BASE (FB_BASE)
  ) u_cmd (
    .PLB_clk    (PLB_clk),
    .arst_n     (arst_n),
    .load_pixel (load_pixel),
    .load_flush (load_flush),
    .pixel      (rd_data),
    .flush_line (flush_line),
    .flush_col  (flush_col),
    .cmd        (cmd)
  );

  // Bus side of the command
  assign mst_addr = cmd.addr;
  assign mst_wr_d = cmd.data;

endmodule

//--- fb_writer/fbw_ctrl.sv
module fbw_ctrl (
  input  logic                  PLB_clk,
  input  logic                  arst_n,
  input  logic                  empty,
  input  fbw_pkg::raster_word_t rd_data,
  input  logic                  flush_last,
  input  logic                  mst_cmd_ack,
  input  logic                  mst_cmplt,
  output logic                  pop,
  output logic                  load_pixel,
  output logic                  load_flush,
  output logic                  flush_start,
  output logic                  step,
  output logic                  mst_wr_req,
  output logic                  idle
);

  fbw_pkg::fbw_state_e state;
  fbw_pkg::fbw_state_e state_nxt;

  logic flushing;
  logic is_marker;

  assign is_marker = (rd_data == fbw_pkg::FLUSH_MARKER);

  ////////////////////////////////////////////////////
  // State register and flush flag
  ////////////////////////////////////////////////////

  always_ff @(posedge PLB_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= fbw_pkg::IDLE;
      flushing <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state == fbw_pkg::DECODE && is_marker)
        flushing <= 1'b1;
      else if (state == fbw_pkg::WAIT_CMPLT && mst_cmplt && flush_last)
        flushing <= 1'b0;
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      fbw_pkg::IDLE:
        if (!empty)
          state_nxt = fbw_pkg::POP;
      fbw_pkg::POP:
        state_nxt = fbw_pkg::DECODE;
      fbw_pkg::DECODE:
        state_nxt = fbw_pkg::REQ;
      fbw_pkg::REQ:
        if (mst_cmd_ack)
          state_nxt = fbw_pkg::WAIT_CMPLT;
      fbw_pkg::WAIT_CMPLT:
        if (mst_cmplt)
          // Next flush position unless this was the last
          state_nxt = (flushing && !flush_last) ? fbw_pkg::FLUSH_NEXT : fbw_pkg::IDLE;
      fbw_pkg::FLUSH_NEXT:
        state_nxt = fbw_pkg::REQ;
      default:
        state_nxt = fbw_pkg::IDLE;
    endcase
  end

  ////////////////////////////////////////////////////
  // Outputs decoded from state
  ////////////////////////////////////////////////////

  assign pop         = (state == fbw_pkg::POP);
  assign load_pixel  = (state == fbw_pkg::DECODE) && !is_marker;
  assign flush_start = (state == fbw_pkg::DECODE) && is_marker;
  assign step        = (state == fbw_pkg::FLUSH_NEXT);
  assign load_flush  = flush_start || step;
  assign mst_wr_req  = (state == fbw_pkg::REQ);
  assign idle        = (state == fbw_pkg::IDLE) && empty;

  // Acknowledge only answers a pending write request
  a_ack_in_req: assert property (@(posedge PLB_clk) disable iff (!arst_n)
    mst_cmd_ack |-> mst_wr_req);

  // Completion only arrives while a write is outstanding
  a_cmplt_in_wait: assert property (@(posedge PLB_clk) disable iff (!arst_n)
    mst_cmplt |-> state == fbw_pkg::WAIT_CMPLT);

endmodule

//--- fb_writer/fbw_cmd_reg.sv
module fbw_cmd_reg #(
  parameter fbw_pkg::fb_base_t FB_BASE = 11'b1001_0000_000
) (
  input  logic                  PLB_clk,
  input  logic                  arst_n,
  input  logic                  load_pixel,
  input  logic                  load_flush,
  input  fbw_pkg::raster_word_t pixel,
  input  fbw_pkg::line_t        flush_line,
  input  fbw_pkg::col_t         flush_col,
  output fbw_pkg::mst_cmd_t     cmd
);

  fbw_pkg::line_t  sel_line;
  fbw_pkg::col_t   sel_col;
  fbw_pkg::color_t sel_color;

  // Pixel fields or flush position
  always_comb
  begin
    if (load_pixel)
    begin
      sel_line  = pixel.line;
      sel_col   = pixel.col;
      sel_color = pixel.color;
    end
    else
    begin
      sel_line  = flush_line;
      sel_col   = flush_col;
      sel_color = fbw_pkg::FLUSH_COLOR;
    end
  end

  // Address is base, line, column, word aligned
  always_ff @(posedge PLB_clk or negedge arst_n)
  begin
    if (!arst_n)
      cmd <= '0;
    else if (load_pixel || load_flush)
    begin
      cmd.addr <= {FB_BASE, sel_line, sel_col, 2'b00};
      cmd.data <= sel_color;
    end
  end

endmodule

//--- fb_writer/fbw_flush_counter.sv
module fbw_flush_counter #(
  parameter int FLUSH_LINES = 10,
  parameter int FLUSH_COLS  = 20
) (
  input  logic           PLB_clk,
  input  logic           arst_n,
  input  logic           flush_start,
  input  logic           step,
  output fbw_pkg::line_t line,
  output fbw_pkg::col_t  col,
  output logic           last
);

  localparam fbw_pkg::line_t LINE_MAX = fbw_pkg::line_t'(FLUSH_LINES - 1);
  localparam fbw_pkg::col_t  COL_MAX  = fbw_pkg::col_t'(FLUSH_COLS - 1);

  fbw_pkg::line_t cur_line;
  fbw_pkg::col_t  cur_col;
  fbw_pkg::line_t nxt_line;
  fbw_pkg::col_t  nxt_col;

  // Column runs down first, then the line
  always_comb
  begin
    nxt_line = cur_line;
    nxt_col  = cur_col;
    if (flush_start)
    begin
      nxt_line = LINE_MAX;
      nxt_col  = COL_MAX;
    end
    else if (step)
    begin
      if (cur_col == '0)
      begin
        nxt_col  = COL_MAX;
        nxt_line = cur_line - 1'b1;
      end
      else
        nxt_col = cur_col - 1'b1;
    end
  end

  always_ff @(posedge PLB_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cur_line <= '0;
      cur_col  <= '0;
    end
    else
    begin
      cur_line <= nxt_line;
      cur_col  <= nxt_col;
    end
  end

  // Position being loaded, so the command register moves with the counter
  assign line = nxt_line;
  assign col  = nxt_col;
  assign last = (cur_line == '0) && (cur_col == '0);

  a_no_step_last: assert property (@(posedge PLB_clk) disable iff (!arst_n)
    step |-> !last);

endmodule

//--- src/pixel_fifo.sv
module pixel_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  PLB_clk,
  input  logic                  arst_n,
  input  logic                  push,
  input  fbw_pkg::raster_word_t push_data,
  input  logic                  pop,
  output fbw_pkg::raster_word_t rd_data,
  output logic                  full,
  output logic                  empty
);

  localparam int AW = $clog2(FIFO_DEPTH);

  fbw_pkg::raster_word_t mem [FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          wr_en;
  logic          rd_en;

  assign full  = (count == FIFO_DEPTH);
  assign empty = (count == '0);
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  // Pointers wrap by themselves, depth is a power of two
  always_ff @(posedge PLB_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge PLB_clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_data;
  end

  // Registered read port, data follows the pop by one cycle
  always_ff @(posedge PLB_clk)
  begin
    if (rd_en)
      rd_data <= mem[rd_ptr];
  end

  a_no_push_full: assert property (@(posedge PLB_clk) disable iff (!arst_n)
    push |-> !full);

  a_no_pop_empty: assert property (@(posedge PLB_clk) disable iff (!arst_n)
    pop |-> !empty);

endmodule

//--- common/fbw_pkg.sv
package fbw_pkg;

  // Pixel coordinates and colour
  typedef logic [8:0]  line_t;
  typedef logic [9:0]  col_t;
  typedef logic [31:0] color_t;

  // Bus address and the frame-buffer base in its top bits
  typedef logic [31:0] addr_t;
  typedef logic [10:0] fb_base_t;

  // Raster word as pushed by the rasterizer
  typedef struct packed {
    logic [6:0] pad_hi;
    line_t      line;
    logic [5:0] pad_lo;
    col_t       col;
    color_t     color;
  } raster_word_t;

  // All ones starts a flush of the region
  localparam raster_word_t FLUSH_MARKER = '1;
  localparam color_t       FLUSH_COLOR  = '0;

  // Single-word write command on the bus master side
  typedef struct packed {
    addr_t  addr;
    color_t data;
  } mst_cmd_t;

  // Writer controller states
  typedef enum logic [2:0] {
    IDLE,
    POP,
    DECODE,
    REQ,
    WAIT_CMPLT,
    FLUSH_NEXT
  } fbw_state_e;

endpackage
